//--- Makefile
# Verilator build and run for the OTP checker testbench

VERILATOR ?= verilator
TOP       ?= tb_otp_chk
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
GOLDEN    ?= tests/otp_chk_golden.txt
VFLAGS    ?= --binary --timing -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell cat $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# The simulation runs from the project root so the golden path resolves
run: compile $(GOLDEN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
hdl/otp_chk_pkg.sv
hdl/chk_req_if.sv
hdl/chk_lfsr.sv
hdl/chk_timer.sv
hdl/part_checker.sv
hdl/chk_err_agg.sv
hdl/otp_chk_top.sv
tests/tb_otp_chk.sv

//--- hdl/chk_err_agg.sv
// Check error status and alert
`timescale 1ns/1ps

module chk_err_agg #(
  parameter int NumPart = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [NumPart-1:0] integ_err_i,
  input  logic [NumPart-1:0] cnsty_err_i,
  input  logic               chk_timeout_i,
  input  logic               fsm_err_i,
  output logic [NumPart-1:0] integ_err_o,
  output logic [NumPart-1:0] cnsty_err_o,
  output logic               alert_o
);

  logic [NumPart-1:0] integ_err_q;
  logic [NumPart-1:0] cnsty_err_q;

  // Per-partition status, cleared only by reset
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_sticky
    if (!rst_ni) begin
      integ_err_q <= '0;
      cnsty_err_q <= '0;
    end else begin
      integ_err_q <= integ_err_q | integ_err_i;
      cnsty_err_q <= cnsty_err_q | cnsty_err_i;
    end
  end

  assign integ_err_o = integ_err_q;
  assign cnsty_err_o = cnsty_err_q;

  // Single alert for any recorded fault
  assign alert_o = (|integ_err_q) | (|cnsty_err_q) | chk_timeout_i | fsm_err_i;

endmodule

//--- hdl/chk_lfsr.sv
// Reseedable wait-time LFSR
`timescale 1ns/1ps

module chk_lfsr (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 draw_i,
  input  logic                                 edn_ack_i,
  input  logic [otp_chk_pkg::EntropyWidth-1:0] edn_data_i,
  output logic                                 edn_req_o,
  output logic [otp_chk_pkg::LfsrWidth-1:0]    state_o
);
  import otp_chk_pkg::*;

  // Galois feedback for x^40 + x^38 + x^21 + x^19 + 1
  localparam logic [LfsrWidth-1:0] Taps = 40'hA0_0014_0000;
  localparam int CntWidth = $clog2(LfsrUsageThreshold + 1);

  logic [CntWidth-1:0]  use_cnt_q, use_cnt_d;
  logic [LfsrWidth-1:0] state_q, state_d, state_step;
  logic                 reseed;

  ////////////////////////////////
  // Usage counter
  ////////////////////////////////

  // Request stays up until the entropy source answers
  assign edn_req_o = (use_cnt_q >= CntWidth'(LfsrUsageThreshold));
  assign reseed    = edn_req_o & edn_ack_i;

  // Saturates while the reseed is outstanding, draws keep going
  always_comb begin : p_use_cnt
    use_cnt_d = use_cnt_q;
    if (reseed) begin
      use_cnt_d = '0;
    end else if (draw_i && !edn_req_o) begin
      use_cnt_d = use_cnt_q + CntWidth'(1);
    end
  end

  ////////////////////////////////
  // LFSR state
  ////////////////////////////////

  // Shift right, fold the dropped bit back into the taps
  assign state_step = {1'b0, state_q[LfsrWidth-1:1]} ^ (state_q[0] ? Taps : '0);

  always_comb begin : p_state
    state_d = draw_i ? state_step : state_q;
    // Fresh entropy mixed in on the acknowledge cycle
    if (reseed) begin
      state_d = state_d ^ LfsrWidth'(edn_data_i);
    end
    // All-zero state would lock up
    if (state_d == '0) begin
      state_d = LfsrSeed;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      use_cnt_q <= '0;
      state_q   <= LfsrSeed;
    end else begin
      use_cnt_q <= use_cnt_d;
      state_q   <= state_d;
    end
  end

  assign state_o = state_q;

endmodule

//--- hdl/chk_req_if.sv
// Partition check request bundle
`timescale 1ns/1ps

interface chk_req_if;

  // Check requests, held by the timer until acknowledged
  logic integ_req;
  logic cnsty_req;
  // One-cycle acknowledge pulses from the partition
  logic integ_ack;
  logic cnsty_ack;

  // Scheduler side
  modport timer (
    output integ_req,
    output cnsty_req,
    input  integ_ack,
    input  cnsty_ack
  );

  // Partition side
  modport part (
    input  integ_req,
    input  cnsty_req,
    output integ_ack,
    output cnsty_ack
  );

endinterface

//--- hdl/chk_timer.sv
// Background check scheduler
`timescale 1ns/1ps

module chk_timer #(
  parameter int NumPart = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 timer_en_i,
  input  logic                                 prog_busy_i,
  input  logic                                 integ_trig_i,
  input  logic                                 cnsty_trig_i,
  input  logic                                 esc_i,
  input  logic [31:0]                          timeout_i,
  input  logic [31:0]                          integ_period_msk_i,
  input  logic [31:0]                          cnsty_period_msk_i,
  input  logic                                 edn_ack_i,
  input  logic [otp_chk_pkg::EntropyWidth-1:0] edn_data_i,
  output logic                                 edn_req_o,
  output logic                                 chk_pending_o,
  output logic                                 chk_timeout_o,
  output logic                                 fsm_err_o,
  chk_req_if.timer                             req_if [NumPart]
);
  import otp_chk_pkg::*;

  ////////////////////////////////
  // Wait value source
  ////////////////////////////////

  logic                 lfsr_draw;
  logic [LfsrWidth-1:0] lfsr_state;

  chk_lfsr u_chk_lfsr (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .draw_i     (lfsr_draw),
    .edn_ack_i  (edn_ack_i),
    .edn_data_i (edn_data_i),
    .edn_req_o  (edn_req_o),
    .state_o    (lfsr_state)
  );

  ////////////////////////////////
  // Wait and timeout counters
  ////////////////////////////////

  logic [LfsrWidth-1:0] integ_cnt_q, integ_cnt_d;
  logic [LfsrWidth-1:0] cnsty_cnt_q, cnsty_cnt_d;
  logic integ_set_period, integ_set_timeout;
  logic cnsty_set_period, cnsty_set_timeout;
  logic cnsty_cnt_pause;
  logic timeout_zero, integ_msk_zero, cnsty_msk_zero;
  logic integ_cnt_zero, cnsty_cnt_zero;

  assign timeout_zero   = (timeout_i == '0);
  assign integ_msk_zero = (integ_period_msk_i == '0);
  assign cnsty_msk_zero = (cnsty_period_msk_i == '0);
  assign integ_cnt_zero = (integ_cnt_q == '0);
  assign cnsty_cnt_zero = (cnsty_cnt_q == '0);

  // Load a masked period or the timeout, else count down to zero
  function automatic logic [LfsrWidth-1:0] cnt_next(
    input logic [LfsrWidth-1:0] cnt,
    input logic                 set_period,
    input logic                 set_timeout,
    input logic [31:0]          msk,
    input logic                 pause
  );
    logic [LfsrWidth-1:0] nxt;
    nxt = cnt;
    if (set_period) begin
      nxt = lfsr_state & LfsrWidth'(msk);
    end else if (set_timeout) begin
      nxt = LfsrWidth'(timeout_i);
    end else if ((cnt != '0) && !pause) begin
      nxt = cnt - LfsrWidth'(1);
    end
    return nxt;
  endfunction

  assign integ_cnt_d = cnt_next(integ_cnt_q, integ_set_period, integ_set_timeout,
                                integ_period_msk_i, 1'b0);
  assign cnsty_cnt_d = cnt_next(cnsty_cnt_q, cnsty_set_period, cnsty_set_timeout,
                                cnsty_period_msk_i, cnsty_cnt_pause);

  ////////////////////////////////
  // Partition requests
  ////////////////////////////////

  logic [NumPart-1:0] integ_req_q, integ_req_d, integ_ack;
  logic [NumPart-1:0] cnsty_req_q, cnsty_req_d, cnsty_ack;
  logic set_all_integ, set_all_cnsty;
  logic in_error;
  timer_state_e state_q, state_d;

  for (genvar k = 0; k < NumPart; k++) begin : g_req
    assign req_if[k].integ_req = integ_req_q[k];
    assign req_if[k].cnsty_req = cnsty_req_q[k];
    assign integ_ack[k]        = req_if[k].integ_ack;
    assign cnsty_ack[k]        = req_if[k].cnsty_ack;
  end

  // Raise all at once, drop each on the cycle after its ack
  // Everything drops in the error state
  assign in_error    = (state_q == ErrorSt);
  assign integ_req_d = set_all_integ ? '1 :
                       (integ_req_q & ~integ_ack & {NumPart{!in_error}});
  assign cnsty_req_d = set_all_cnsty ? '1 :
                       (cnsty_req_q & ~cnsty_ack & {NumPart{!in_error}});

  // One-off triggers, sticky until the check starts
  logic integ_trig_q, cnsty_trig_q;
  logic clr_integ_trig, clr_cnsty_trig;

  ////////////////////////////////
  // Scheduler FSM
  ////////////////////////////////

  logic chk_timeout_q, chk_timeout_d;

  assign chk_timeout_o = chk_timeout_q;

  always_comb begin : p_fsm
    state_d           = state_q;
    lfsr_draw         = 1'b0;
    integ_set_period  = 1'b0;
    cnsty_set_period  = 1'b0;
    integ_set_timeout = 1'b0;
    cnsty_set_timeout = 1'b0;
    cnsty_cnt_pause   = 1'b0;
    set_all_integ     = 1'b0;
    set_all_cnsty     = 1'b0;
    clr_integ_trig    = 1'b0;
    clr_cnsty_trig    = 1'b0;
    chk_timeout_d     = chk_timeout_q;
    chk_pending_o     = integ_trig_q | cnsty_trig_q;
    fsm_err_o         = 1'b0;

    unique case (state_q)
      // Leave once enabled and never come back
      ResetSt: begin
        if (timer_en_i) begin
          state_d          = IdleSt;
          lfsr_draw        = 1'b1;
          integ_set_period = 1'b1;
          cnsty_set_period = 1'b1;
        end
      end
      // Expired period or latched trigger starts a check
      // Integrity wins when both are due
      IdleSt: begin
        if ((!integ_msk_zero && integ_cnt_zero) || integ_trig_q) begin
          state_d           = IntegWaitSt;
          integ_set_timeout = 1'b1;
          set_all_integ     = 1'b1;
          clr_integ_trig    = integ_trig_q;
        end else if ((!cnsty_msk_zero && cnsty_cnt_zero) || cnsty_trig_q) begin
          state_d           = CnstyWaitSt;
          cnsty_set_timeout = 1'b1;
          set_all_cnsty     = 1'b1;
          clr_cnsty_trig    = cnsty_trig_q;
        end
      end
      // Wait for every partition, counter doubles as timeout
      IntegWaitSt: begin
        chk_pending_o = 1'b1;
        if (!timeout_zero && integ_cnt_zero) begin
          state_d       = ErrorSt;
          chk_timeout_d = 1'b1;
        end else if (integ_req_q == '0) begin
          state_d          = IdleSt;
          integ_set_period = 1'b1;
          lfsr_draw        = 1'b1;
        end
      end
      // Programming may stall the array reads, timeout holds meanwhile
      CnstyWaitSt: begin
        chk_pending_o   = 1'b1;
        cnsty_cnt_pause = prog_busy_i;
        if (!timeout_zero && cnsty_cnt_zero) begin
          state_d       = ErrorSt;
          chk_timeout_d = 1'b1;
        end else if (cnsty_req_q == '0) begin
          state_d          = IdleSt;
          cnsty_set_period = 1'b1;
          lfsr_draw        = 1'b1;
        end
      end
      // Terminal, new triggers are flushed and never show as pending
      ErrorSt: begin
        chk_pending_o  = 1'b0;
        clr_integ_trig = 1'b1;
        clr_cnsty_trig = 1'b1;
        if (!chk_timeout_q) begin
          fsm_err_o = 1'b1;
        end
      end
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation overrides everything
    if (esc_i) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
    end
  end

  ////////////////////////////////
  // Registers
  ////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q       <= ResetSt;
      chk_timeout_q <= 1'b0;
      integ_cnt_q   <= '0;
      cnsty_cnt_q   <= '0;
      integ_req_q   <= '0;
      cnsty_req_q   <= '0;
      integ_trig_q  <= 1'b0;
      cnsty_trig_q  <= 1'b0;
    end else begin
      state_q       <= state_d;
      chk_timeout_q <= chk_timeout_d;
      integ_cnt_q   <= integ_cnt_d;
      cnsty_cnt_q   <= cnsty_cnt_d;
      integ_req_q   <= integ_req_d;
      cnsty_req_q   <= cnsty_req_d;
      integ_trig_q  <= (integ_trig_q & ~clr_integ_trig) | integ_trig_i;
      cnsty_trig_q  <= (cnsty_trig_q & ~clr_cnsty_trig) | cnsty_trig_i;
    end
  end

endmodule

//--- hdl/otp_chk_pkg.sv
// OTP checker shared definitions
package otp_chk_pkg;

  //////////////////////////////
  // LFSR and wait counters
  //////////////////////////////

  // Width of the LFSR and both wait counters
  localparam int LfsrWidth = 40;
  // Width of the entropy word from the reseed source
  localparam int EntropyWidth = 40;
  // Draws before a reseed is requested
  localparam int LfsrUsageThreshold = 8;
  // Reset state, must not be zero
  localparam logic [LfsrWidth-1:0] LfsrSeed = 40'h5A_C3E1_7B29;

  //////////////////////////////
  // Partition storage
  //////////////////////////////

  // Data words per partition, digest sits right after them
  localparam int PartWords = 4;
  localparam int DataWidth = 32;
  localparam int AddrWidth = 3;

  //////////////////////////////
  // Check timer FSM
  //////////////////////////////

  typedef enum logic [2:0] {
    ResetSt,
    IdleSt,
    IntegWaitSt,
    CnstyWaitSt,
    ErrorSt
  } timer_state_e;

endpackage

//--- hdl/otp_chk_top.sv
// OTP background checker top
`timescale 1ns/1ps

module otp_chk_top #(
  parameter int NumPart = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 timer_en_i,
  input  logic                                 prog_busy_i,
  input  logic                                 integ_trig_i,
  input  logic                                 cnsty_trig_i,
  input  logic                                 esc_i,
  input  logic [31:0]                          timeout_i,
  input  logic [31:0]                          integ_period_msk_i,
  input  logic [31:0]                          cnsty_period_msk_i,
  input  logic                                 edn_ack_i,
  input  logic [otp_chk_pkg::EntropyWidth-1:0] edn_data_i,
  output logic                                 edn_req_o,
  output logic                                 chk_pending_o,
  output logic                                 chk_timeout_o,
  output logic                                 fsm_err_o,
  input  logic                                 wr_en_i,
  input  logic [$clog2(NumPart)-1:0]           wr_part_i,
  input  logic [1:0]                           wr_sel_i,
  input  logic [otp_chk_pkg::AddrWidth-1:0]    wr_addr_i,
  input  logic [otp_chk_pkg::DataWidth-1:0]    wr_data_i,
  output logic [NumPart-1:0]                   integ_err_o,
  output logic [NumPart-1:0]                   cnsty_err_o,
  output logic                                 alert_o
);

  localparam int PartSelW = $clog2(NumPart);

  // One request bundle per partition
  chk_req_if req_if [NumPart] ();

  logic [NumPart-1:0] part_integ_err;
  logic [NumPart-1:0] part_cnsty_err;

  chk_timer #(
    .NumPart (NumPart)
  ) u_chk_timer (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .timer_en_i         (timer_en_i),
    .prog_busy_i        (prog_busy_i),
    .integ_trig_i       (integ_trig_i),
    .cnsty_trig_i       (cnsty_trig_i),
    .esc_i              (esc_i),
    .timeout_i          (timeout_i),
    .integ_period_msk_i (integ_period_msk_i),
    .cnsty_period_msk_i (cnsty_period_msk_i),
    .edn_ack_i          (edn_ack_i),
    .edn_data_i         (edn_data_i),
    .edn_req_o          (edn_req_o),
    .chk_pending_o      (chk_pending_o),
    .chk_timeout_o      (chk_timeout_o),
    .fsm_err_o          (fsm_err_o),
    .req_if             (req_if)
  );

  for (genvar k = 0; k < NumPart; k++) begin : g_part
    // Write strobe only for the addressed partition
    logic part_wr_en;
    assign part_wr_en = wr_en_i & (wr_part_i == PartSelW'(k));

    part_checker u_part_checker (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .prog_busy_i (prog_busy_i),
      .wr_en_i     (part_wr_en),
      .wr_sel_i    (wr_sel_i),
      .wr_addr_i   (wr_addr_i),
      .wr_data_i   (wr_data_i),
      .req_if      (req_if[k]),
      .integ_err_o (part_integ_err[k]),
      .cnsty_err_o (part_cnsty_err[k])
    );
  end

  chk_err_agg #(
    .NumPart (NumPart)
  ) u_chk_err_agg (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .integ_err_i   (part_integ_err),
    .cnsty_err_i   (part_cnsty_err),
    .chk_timeout_i (chk_timeout_o),
    .fsm_err_i     (fsm_err_o),
    .integ_err_o   (integ_err_o),
    .cnsty_err_o   (cnsty_err_o),
    .alert_o       (alert_o)
  );

endmodule

//--- hdl/part_checker.sv
// Partition storage and scan engine
`timescale 1ns/1ps

module part_checker (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              prog_busy_i,
  input  logic                              wr_en_i,
  input  logic [1:0]                        wr_sel_i,
  input  logic [otp_chk_pkg::AddrWidth-1:0] wr_addr_i,
  input  logic [otp_chk_pkg::DataWidth-1:0] wr_data_i,
  chk_req_if.part                           req_if,
  output logic                              integ_err_o,
  output logic                              cnsty_err_o
);
  import otp_chk_pkg::*;

  localparam int NumWords = PartWords + 1;
  localparam logic [AddrWidth-1:0] DigestAddr = AddrWidth'(PartWords);

  ////////////////////////////////
  // Storage
  ////////////////////////////////

  // Array copy and buffered copy, digest in the last word
  logic [DataWidth-1:0] arr_mem [NumWords];
  logic [DataWidth-1:0] buf_mem [NumWords];

  always_ff @(posedge clk_i) begin : p_wr
    if (wr_en_i && (wr_addr_i <= DigestAddr)) begin
      if (wr_sel_i[0]) begin
        arr_mem[wr_addr_i] <= wr_data_i;
      end
      if (wr_sel_i[1]) begin
        buf_mem[wr_addr_i] <= wr_data_i;
      end
    end
  end

  ////////////////////////////////
  // Scan engine
  ////////////////////////////////

  logic                 req_any, is_integ, scanning, step, last;
  logic                 done_q, mism_q;
  logic [AddrWidth-1:0] addr_q;
  logic [DataWidth-1:0] fold_q, arr_word, buf_word;
  logic                 integ_fail, cnsty_fail;
  logic                 integ_ack_q, cnsty_ack_q, integ_err_q, cnsty_err_q;

  assign req_any  = req_if.integ_req | req_if.cnsty_req;
  assign is_integ = req_if.integ_req;
  // Idle again once the request has gone
  assign scanning = req_any & ~done_q;
  // One word per cycle, frozen while programming
  assign step     = scanning & ~prog_busy_i;
  assign last     = step & (addr_q == DigestAddr);

  assign arr_word = arr_mem[addr_q];
  assign buf_word = buf_mem[addr_q];

  // Fold of the data words against the digest
  assign integ_fail = (fold_q != arr_word);
  // Any word differing between the two copies
  assign cnsty_fail = mism_q | (arr_word != buf_word);

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_scan
    if (!rst_ni) begin
      addr_q      <= '0;
      fold_q      <= '0;
      mism_q      <= 1'b0;
      done_q      <= 1'b0;
      integ_ack_q <= 1'b0;
      cnsty_ack_q <= 1'b0;
      integ_err_q <= 1'b0;
      cnsty_err_q <= 1'b0;
    end else begin
      done_q      <= (done_q | last) & req_any;
      // Ack and error leave together as one-cycle pulses
      integ_ack_q <= last & is_integ;
      cnsty_ack_q <= last & ~is_integ;
      integ_err_q <= last & is_integ & integ_fail;
      cnsty_err_q <= last & ~is_integ & cnsty_fail;
      if (!scanning) begin
        addr_q <= '0;
        fold_q <= '0;
        mism_q <= 1'b0;
      end else if (step) begin
        addr_q <= last ? '0 : addr_q + AddrWidth'(1);
        fold_q <= fold_q ^ arr_word;
        mism_q <= cnsty_fail;
      end
    end
  end

  assign req_if.integ_ack = integ_ack_q;
  assign req_if.cnsty_ack = cnsty_ack_q;
  assign integ_err_o      = integ_err_q;
  assign cnsty_err_o      = cnsty_err_q;

endmodule

//--- tests/otp_chk_golden.txt
# cmd args in hex: fill part | write part sel addr data | config en timeout imsk cmsk
# trigger 0=integ 1=cnsty | busy v | escalate | waitidle | run n | watch n seen | draws n | reseed
# expect integ_err cnsty_err alert timeout fsm_err pending edn_req
fill 0
fill 1
fill 2
fill 3
config 1 40 0 0
expect 0 0 0 0 0 0 0
trigger 0
waitidle
expect 0 0 0 0 0 0 0
write 2 3 4 0badd16e
trigger 0
waitidle
expect 4 0 1 0 0 0 0
write 1 2 1 5a5a5a5a
trigger 1
waitidle
expect 4 2 1 0 0 0 0
watch 12c 0
config 1 40 f f
watch 12c 1
config 1 40 0 0
waitidle
expect 4 2 1 0 0 0 1
reseed
draws 7
expect 4 2 1 0 0 0 0
draws 1
expect 4 2 1 0 0 0 1
reseed
config 1 10 0 0
busy 1
trigger 1
run 3c
expect 4 2 1 0 0 1 0
busy 0
waitidle
expect 4 2 1 0 0 0 0
busy 1
trigger 0
run 3c
expect 4 2 1 1 0 0 0
busy 0
trigger 0
run 14
expect 4 2 1 1 0 0 0
escalate
expect 4 2 1 1 1 0 0

//--- tests/tb_otp_chk.sv
// OTP checker testbench
`timescale 1ns/1ps

module tb_otp_chk;
  import otp_chk_pkg::*;

  localparam int    NumPart    = 4;
  localparam int    ClkPeriod  = 40;
  localparam int    LineCycles = 200;
  localparam string GoldenFile = "tests/otp_chk_golden.txt";

  logic                    clk_i, rst_ni;
  logic                    timer_en_i, prog_busy_i, integ_trig_i, cnsty_trig_i, esc_i;
  logic [31:0]             timeout_i, integ_period_msk_i, cnsty_period_msk_i;
  logic                    edn_ack_i;
  logic [EntropyWidth-1:0] edn_data_i;
  logic                    wr_en_i;
  logic [1:0]              wr_part_i, wr_sel_i;
  logic [AddrWidth-1:0]    wr_addr_i;
  logic [DataWidth-1:0]    wr_data_i;
  logic                    edn_req_o, chk_pending_o, chk_timeout_o, fsm_err_o, alert_o;
  logic [NumPart-1:0]      integ_err_o, cnsty_err_o;

  int   cycle_cnt   = 0;
  int   cycle_limit = LineCycles;
  logic pend_seen   = 1'b0;

  otp_chk_top #(
    .NumPart (NumPart)
  ) i_otp_chk_top (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .timer_en_i         (timer_en_i),
    .prog_busy_i        (prog_busy_i),
    .integ_trig_i       (integ_trig_i),
    .cnsty_trig_i       (cnsty_trig_i),
    .esc_i              (esc_i),
    .timeout_i          (timeout_i),
    .integ_period_msk_i (integ_period_msk_i),
    .cnsty_period_msk_i (cnsty_period_msk_i),
    .edn_ack_i          (edn_ack_i),
    .edn_data_i         (edn_data_i),
    .edn_req_o          (edn_req_o),
    .chk_pending_o      (chk_pending_o),
    .chk_timeout_o      (chk_timeout_o),
    .fsm_err_o          (fsm_err_o),
    .wr_en_i            (wr_en_i),
    .wr_part_i          (wr_part_i),
    .wr_sel_i           (wr_sel_i),
    .wr_addr_i          (wr_addr_i),
    .wr_data_i          (wr_data_i),
    .integ_err_o        (integ_err_o),
    .cnsty_err_o        (cnsty_err_o),
    .alert_o            (alert_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic fail_stop();
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("error: %0t ns %s got %0h expected %0h", $time, name, got, exp);
      fail_stop();
    end
  endtask

  // One cycle, outputs sampled at the falling edge where they are settled
  task automatic tick();
    @(negedge clk_i);
    cycle_cnt++;
    if (chk_pending_o) begin
      pend_seen = 1'b1;
    end
    assert (cycle_cnt < cycle_limit) else begin
      $display("timeout: simulation ran past %0d cycles", cycle_limit);
      fail_stop();
    end
  endtask

  task automatic write_word(input logic [1:0] part, input logic [1:0] sel,
                            input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data);
    wr_en_i   = 1'b1;
    wr_part_i = part;
    wr_sel_i  = sel;
    wr_addr_i = addr;
    wr_data_i = data;
    tick();
    wr_en_i   = 1'b0;
  endtask

  // Random data in both copies, digest is the XOR fold of those words
  task automatic fill_part(input logic [1:0] part);
    logic [DataWidth-1:0] word;
    logic [DataWidth-1:0] fold;
    fold = '0;
    for (int i = 0; i < PartWords; i++) begin
      word = $urandom();
      fold = fold ^ word;
      write_word(part, 2'b11, AddrWidth'(i), word);
    end
    write_word(part, 2'b11, AddrWidth'(PartWords), fold);
  endtask

  // Single-cycle trigger pulse
  task automatic pulse_trig(input logic kind);
    integ_trig_i = ~kind;
    cnsty_trig_i = kind;
    tick();
    integ_trig_i = 1'b0;
    cnsty_trig_i = 1'b0;
  endtask

  // Back to idle, bounded by the cycle limit
  task automatic wait_idle();
    while (chk_pending_o) begin
      tick();
    end
  endtask

  // Answer the entropy request with a random word
  task automatic answer_reseed();
    logic [63:0] rnd;
    while (!edn_req_o) begin
      tick();
    end
    rnd        = {$urandom(), $urandom()};
    edn_data_i = rnd[EntropyWidth-1:0];
    edn_ack_i  = 1'b1;
    tick();
    edn_ack_i  = 1'b0;
    check_val("edn_req_o", 64'(edn_req_o), 64'd0);
  endtask

  //////////////////////////////
  // Golden file interpreter
  //////////////////////////////

  initial begin : p_main
    int          fd, rc, n_lines, n_expect;
    string       line, cmd;
    logic [63:0] arg [7];
    n_lines  = 0;
    n_expect = 0;
    void'($urandom(32'hF971));
    {clk_i, rst_ni, timer_en_i, prog_busy_i, integ_trig_i, cnsty_trig_i, esc_i} = '0;
    {timeout_i, integ_period_msk_i, cnsty_period_msk_i} = '0;
    {edn_ack_i, edn_data_i, wr_en_i, wr_part_i, wr_sel_i, wr_addr_i, wr_data_i} = '0;

    // First pass sizes the cycle budget
    fd = $fopen(GoldenFile, "r");
    if (fd == 0) begin
      $display("cannot open golden file %s", GoldenFile);
      fail_stop();
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) > 0) begin
        n_lines++;
      end
    end
    $fclose(fd);
    cycle_limit = LineCycles * n_lines;

    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;

    fd = $fopen(GoldenFile, "r");
    while (!$feof(fd)) begin
      line = "";
      rc   = $fgets(line, fd);
      // Skip blanks and column notes
      if (rc == 0 || line.len() < 2 || line[0] == "#") begin
        continue;
      end
      for (int i = 0; i < 7; i++) begin
        arg[i] = '0;
      end
      rc = $sscanf(line, "%s %h %h %h %h %h %h %h", cmd,
                   arg[0], arg[1], arg[2], arg[3], arg[4], arg[5], arg[6]);
      case (cmd)
        "fill":     fill_part(arg[0][1:0]);
        "write":    write_word(arg[0][1:0], arg[1][1:0], arg[2][AddrWidth-1:0],
                               arg[3][DataWidth-1:0]);
        "trigger":  pulse_trig(arg[0][0]);
        "waitidle": wait_idle();
        "reseed":   answer_reseed();
        "config": begin
          timer_en_i         = arg[0][0];
          timeout_i          = arg[1][31:0];
          integ_period_msk_i = arg[2][31:0];
          cnsty_period_msk_i = arg[3][31:0];
          tick();
        end
        "busy": begin
          prog_busy_i = arg[0][0];
          tick();
        end
        "escalate": begin
          esc_i = 1'b1;
          tick();
        end
        "run": begin
          repeat (int'(arg[0][15:0])) tick();
        end
        // Did a check start anywhere in the window
        "watch": begin
          pend_seen = 1'b0;
          repeat (int'(arg[0][15:0])) tick();
          check_val("chk_pending_o seen", 64'(pend_seen), arg[1]);
        end
        // Completed integrity checks, one LFSR draw each
        "draws": begin
          repeat (int'(arg[0][15:0])) begin
            pulse_trig(1'b0);
            wait_idle();
          end
        end
        "expect": begin
          check_val("integ_err_o", 64'(integ_err_o), arg[0]);
          check_val("cnsty_err_o", 64'(cnsty_err_o), arg[1]);
          check_val("alert_o", 64'(alert_o), arg[2]);
          check_val("chk_timeout_o", 64'(chk_timeout_o), arg[3]);
          check_val("fsm_err_o", 64'(fsm_err_o), arg[4]);
          check_val("chk_pending_o", 64'(chk_pending_o), arg[5]);
          check_val("edn_req_o", 64'(edn_req_o), arg[6]);
          n_expect++;
        end
        default: begin
          $display("unknown golden command %s", cmd);
          fail_stop();
        end
      endcase
    end
    $fclose(fd);

    if (n_expect > 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("golden file held no expect lines");
      fail_stop();
    end
  end

endmodule
